// File: rtl/rob_pkg.sv
package rob_pkg;

    // kind of instruction held in an entry
    // alu writes a register at retire
    // branch writes nothing, may mispredict
    // store is released to the store buffer
    typedef enum logic [1:0] {
        KIND_ALU    = 2'd0,
        KIND_BRANCH = 2'd1,
        KIND_STORE  = 2'd2
    } rob_kind_e;

    // number of entries
    // the tag width is its base-2 log
    parameter int DEF_DEPTH = 16;

    // result data width
    parameter int DEF_DATA_W = 32;

    // pc and branch target width
    parameter int DEF_ADDR_W = 32;

    // architectural register name width
    parameter int DEF_REG_W = 5;

    // fall-through distance of a branch, fixed size encoding
    // a not-taken mispredict redirects to pc + INSTR_BYTES
    parameter int INSTR_BYTES = 4;

endpackage

// File: rtl/rob_alloc.sv
`timescale 1ns/1ps

module rob_alloc #(
    parameter int DEPTH = rob_pkg::DEF_DEPTH,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic             clk,
    input  logic             arst_n,
    input  logic             alloc_en,
    input  logic             pop,
    input  logic             flush,
    output logic [TAG_W-1:0] alloc_tag,
    output logic [TAG_W-1:0] head,
    output logic             full
);

    localparam int COUNT_W = TAG_W + 1;
    localparam logic [TAG_W-1:0] LAST_IDX = TAG_W'(DEPTH - 1);

    logic [TAG_W-1:0]   head_q;
    logic [TAG_W-1:0]   tail_q;
    logic [COUNT_W-1:0] count_q;

    // step an index, wrapping after the last entry
    function automatic logic [TAG_W-1:0] next_idx(input logic [TAG_W-1:0] idx);
        if (idx == LAST_IDX) begin
            return '0;
        end
        return idx + 1'b1;
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush) begin
            // back to empty, next tag handed out is 0
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            if (alloc_en) begin
                tail_q <= next_idx(tail_q);
            end
            if (pop) begin
                head_q <= next_idx(head_q);
            end
            case ({alloc_en, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: ;
            endcase
        end
    end

    // new entry always lands at the tail
    assign alloc_tag = tail_q;
    assign head      = head_q;
    assign full      = (count_q == COUNT_W'(DEPTH));

    // front end must honour full and stay quiet during a flush
    alloc_not_full_a: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_en |-> !full);
    alloc_not_flush_a: assert property (@(posedge clk) disable iff (!arst_n)
        alloc_en |-> !flush);

endmodule

// File: rtl/rob_entries.sv
`timescale 1ns/1ps

module rob_entries #(
    parameter int DEPTH  = rob_pkg::DEF_DEPTH,
    parameter int DATA_W = rob_pkg::DEF_DATA_W,
    parameter int ADDR_W = rob_pkg::DEF_ADDR_W,
    parameter int REG_W  = rob_pkg::DEF_REG_W,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic               clk,
    input  logic               arst_n,
    // allocation at the tail
    input  logic               alloc_en,
    input  logic [TAG_W-1:0]   alloc_tag,
    input  rob_pkg::rob_kind_e alloc_kind,
    input  logic [REG_W-1:0]   alloc_rd,
    input  logic [ADDR_W-1:0]  alloc_pc,
    input  logic               alloc_pred_taken,
    // execution unit writeback
    input  logic               wb_en,
    input  logic [TAG_W-1:0]   wb_tag,
    input  logic [DATA_W-1:0]  wb_data,
    input  logic               wb_taken,
    input  logic [ADDR_W-1:0]  wb_target,
    // store address ready
    input  logic               st_en,
    input  logic [TAG_W-1:0]   st_tag,
    // retire side
    input  logic               pop,
    input  logic               flush,
    input  logic [TAG_W-1:0]   head,
    output logic               head_valid,
    output logic               head_done,
    output rob_pkg::rob_kind_e head_kind,
    output logic [REG_W-1:0]   head_rd,
    output logic [DATA_W-1:0]  head_data,
    output logic [ADDR_W-1:0]  head_pc,
    output logic               head_pred_taken,
    output logic               head_taken,
    output logic [ADDR_W-1:0]  head_target
);

    import rob_pkg::*;

    logic [DEPTH-1:0]  valid_q;
    logic [DEPTH-1:0]  done_q;

    // per-entry payload
    rob_kind_e         kind_q   [DEPTH];
    logic [REG_W-1:0]  rd_q     [DEPTH];
    logic [ADDR_W-1:0] pc_q     [DEPTH];
    logic              pred_q   [DEPTH];
    logic [DATA_W-1:0] data_q   [DEPTH];
    logic              taken_q  [DEPTH];
    logic [ADDR_W-1:0] target_q [DEPTH];

    // entry state flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= '0;
            done_q  <= '0;
        end else if (flush) begin
            // drop everything, writebacks this cycle are lost on purpose
            valid_q <= '0;
            done_q  <= '0;
        end else begin
            if (pop) begin
                valid_q[head] <= 1'b0;
                done_q[head]  <= 1'b0;
            end
            if (alloc_en) begin
                valid_q[alloc_tag] <= 1'b1;
                done_q[alloc_tag]  <= 1'b0;
            end
            if (wb_en) begin
                done_q[wb_tag] <= 1'b1;
            end
            if (st_en) begin
                done_q[st_tag] <= 1'b1;
            end
        end
    end

    // instruction fields from the front end
    always_ff @(posedge clk) begin
        if (alloc_en) begin
            kind_q[alloc_tag] <= alloc_kind;
            rd_q[alloc_tag]   <= alloc_rd;
            pc_q[alloc_tag]   <= alloc_pc;
            pred_q[alloc_tag] <= alloc_pred_taken;
        end
    end

    // results, only trusted once done is set
    always_ff @(posedge clk) begin
        if (wb_en) begin
            data_q[wb_tag]   <= wb_data;
            taken_q[wb_tag]  <= wb_taken;
            target_q[wb_tag] <= wb_target;
        end
    end

    // head read port
    assign head_valid      = valid_q[head];
    assign head_done       = done_q[head];
    assign head_kind       = kind_q[head];
    assign head_rd         = rd_q[head];
    assign head_data       = data_q[head];
    assign head_pc         = pc_q[head];
    assign head_pred_taken = pred_q[head];
    assign head_taken      = taken_q[head];
    assign head_target     = target_q[head];

    // writebacks only for live entries that are still waiting
    wb_live_a: assert property (@(posedge clk) disable iff (!arst_n)
        wb_en && !flush |-> valid_q[wb_tag] && !done_q[wb_tag]);
    st_live_a: assert property (@(posedge clk) disable iff (!arst_n)
        st_en && !flush |-> valid_q[st_tag] && !done_q[st_tag]);

endmodule

// File: rtl/rob_retire.sv
`timescale 1ns/1ps

module rob_retire #(
    parameter int DEPTH  = rob_pkg::DEF_DEPTH,
    parameter int DATA_W = rob_pkg::DEF_DATA_W,
    parameter int ADDR_W = rob_pkg::DEF_ADDR_W,
    parameter int REG_W  = rob_pkg::DEF_REG_W,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic               clk,
    input  logic               arst_n,
    // oldest entry
    input  logic               head_valid,
    input  logic               head_done,
    input  rob_pkg::rob_kind_e head_kind,
    input  logic [REG_W-1:0]   head_rd,
    input  logic [DATA_W-1:0]  head_data,
    input  logic [ADDR_W-1:0]  head_pc,
    input  logic               head_pred_taken,
    input  logic               head_taken,
    input  logic [ADDR_W-1:0]  head_target,
    input  logic [TAG_W-1:0]   head,
    // back to the other stages
    output logic               pop,
    output logic               flush,
    // register commit
    output logic               commit_en,
    output logic [REG_W-1:0]   commit_rd,
    output logic [DATA_W-1:0]  commit_data,
    output logic [TAG_W-1:0]   commit_tag,
    // store buffer release
    output logic               store_release_en,
    output logic [TAG_W-1:0]   store_release_tag,
    output logic [ADDR_W-1:0]  redirect_pc
);

    import rob_pkg::*;

    logic mispredict;
    logic [ADDR_W-1:0] redirect_next;

    // nothing retires while a flush is in progress
    assign pop        = head_valid && head_done && !flush;
    assign mispredict = (head_kind == KIND_BRANCH) && (head_taken != head_pred_taken);

    // taken goes to the target and not taken falls through
    assign redirect_next = head_taken ? head_target : head_pc + ADDR_W'(INSTR_BYTES);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            commit_en        <= 1'b0;
            store_release_en <= 1'b0;
            flush            <= 1'b0;
        end else begin
            commit_en        <= pop && (head_kind == KIND_ALU);
            store_release_en <= pop && (head_kind == KIND_STORE);
            flush            <= pop && mispredict;
        end
    end

    // output fields qualified by the strobes above
    always_ff @(posedge clk) begin
        if (pop) begin
            commit_rd         <= head_rd;
            commit_data       <= head_data;
            commit_tag        <= head;
            store_release_tag <= head;
            redirect_pc       <= redirect_next;
        end
    end

    // an entry of unknown kind would leave without any output
    legal_kind_a: assert property (@(posedge clk) disable iff (!arst_n)
        pop |-> head_kind inside {KIND_ALU, KIND_BRANCH, KIND_STORE});

endmodule

// File: rtl/rob_top.sv
`timescale 1ns/1ps

module rob_top #(
    parameter int DEPTH  = rob_pkg::DEF_DEPTH,
    parameter int DATA_W = rob_pkg::DEF_DATA_W,
    parameter int ADDR_W = rob_pkg::DEF_ADDR_W,
    parameter int REG_W  = rob_pkg::DEF_REG_W,
    localparam int TAG_W = $clog2(DEPTH)
) (
    input  logic               clk,
    input  logic               arst_n,
    // front end
    input  logic               alloc_en,
    input  rob_pkg::rob_kind_e alloc_kind,
    input  logic [REG_W-1:0]   alloc_rd,
    input  logic [ADDR_W-1:0]  alloc_pc,
    input  logic               alloc_pred_taken,
    output logic [TAG_W-1:0]   alloc_tag,
    output logic               full,
    // execution units
    input  logic               wb_en,
    input  logic [TAG_W-1:0]   wb_tag,
    input  logic [DATA_W-1:0]  wb_data,
    input  logic               wb_taken,
    input  logic [ADDR_W-1:0]  wb_target,
    // store address path
    input  logic               st_en,
    input  logic [TAG_W-1:0]   st_tag,
    // retire
    output logic               commit_en,
    output logic [REG_W-1:0]   commit_rd,
    output logic [DATA_W-1:0]  commit_data,
    output logic [TAG_W-1:0]   commit_tag,
    output logic               store_release_en,
    output logic [TAG_W-1:0]   store_release_tag,
    output logic               flush,
    output logic [ADDR_W-1:0]  redirect_pc
);

    import rob_pkg::*;

    logic [TAG_W-1:0]  head;
    logic              pop;
    logic              head_valid;
    logic              head_done;
    rob_kind_e         head_kind;
    logic [REG_W-1:0]  head_rd;
    logic [DATA_W-1:0] head_data;
    logic [ADDR_W-1:0] head_pc;
    logic              head_pred_taken;
    logic              head_taken;
    logic [ADDR_W-1:0] head_target;

    rob_alloc #(
        .DEPTH (DEPTH)
    ) u_alloc (
        .clk       (clk),
        .arst_n    (arst_n),
        .alloc_en  (alloc_en),
        .pop       (pop),
        .flush     (flush),
        .alloc_tag (alloc_tag),
        .head      (head),
        .full      (full)
    );

    rob_entries #(
        .DEPTH  (DEPTH),
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .REG_W  (REG_W)
    ) u_entries (
        .clk              (clk),
        .arst_n           (arst_n),
        .alloc_en         (alloc_en),
        .alloc_tag        (alloc_tag),
        .alloc_kind       (alloc_kind),
        .alloc_rd         (alloc_rd),
        .alloc_pc         (alloc_pc),
        .alloc_pred_taken (alloc_pred_taken),
        .wb_en            (wb_en),
        .wb_tag           (wb_tag),
        .wb_data          (wb_data),
        .wb_taken         (wb_taken),
        .wb_target        (wb_target),
        .st_en            (st_en),
        .st_tag           (st_tag),
        .pop              (pop),
        .flush            (flush),
        .head             (head),
        .head_valid       (head_valid),
        .head_done        (head_done),
        .head_kind        (head_kind),
        .head_rd          (head_rd),
        .head_data        (head_data),
        .head_pc          (head_pc),
        .head_pred_taken  (head_pred_taken),
        .head_taken       (head_taken),
        .head_target      (head_target)
    );

    rob_retire #(
        .DEPTH  (DEPTH),
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .REG_W  (REG_W)
    ) u_retire (
        .clk               (clk),
        .arst_n            (arst_n),
        .head_valid        (head_valid),
        .head_done         (head_done),
        .head_kind         (head_kind),
        .head_rd           (head_rd),
        .head_data         (head_data),
        .head_pc           (head_pc),
        .head_pred_taken   (head_pred_taken),
        .head_taken        (head_taken),
        .head_target       (head_target),
        .head              (head),
        .pop               (pop),
        .flush             (flush),
        .commit_en         (commit_en),
        .commit_rd         (commit_rd),
        .commit_data       (commit_data),
        .commit_tag        (commit_tag),
        .store_release_en  (store_release_en),
        .store_release_tag (store_release_tag),
        .redirect_pc       (redirect_pc)
    );

endmodule

// File: tests/tb_rob_model.svh
`ifndef TB_ROB_MODEL_SVH
`define TB_ROB_MODEL_SVH

// one allocated instruction, result fields hold once done is set
typedef struct packed {
    rob_kind_e         kind;
    logic [TAG_W-1:0]  tag;
    logic [REG_W-1:0]  rd;
    logic [ADDR_W-1:0] pc;
    logic              pred;
    logic              done;
    logic [DATA_W-1:0] data;
    logic              taken;
    logic [ADDR_W-1:0] target;
} instr_t;

typedef enum logic [1:0] {
    EV_NONE,
    EV_COMMIT,
    EV_STORE,
    EV_FLUSH
} ev_kind_e;

// next retire output, and the program order index just past its instruction
typedef struct packed {
    ev_kind_e          kind;
    int                next_idx;
    logic [TAG_W-1:0]  tag;
    logic [REG_W-1:0]  rd;
    logic [DATA_W-1:0] data;
    logic [ADDR_W-1:0] redirect;
} expect_t;

// a branch guessed right leaves the ROB without any output
function automatic bit silent(input instr_t ins);
    return (ins.kind == KIND_BRANCH) && (ins.taken == ins.pred);
endfunction

function automatic expect_t expected_event(input instr_t q[$], input int first);
    expect_t ev;
    int i;
    ev = '0;
    ev.kind = EV_NONE;
    for (i = first; i < q.size(); i++) begin
        // oldest one still waiting blocks everything younger
        if (!q[i].done) begin
            return ev;
        end
        if (!silent(q[i])) begin
            ev.next_idx = i + 1;
            ev.tag      = q[i].tag;
            ev.rd       = q[i].rd;
            ev.data     = q[i].data;
            if (q[i].kind == KIND_ALU) begin
                ev.kind = EV_COMMIT;
            end else if (q[i].kind == KIND_STORE) begin
                ev.kind = EV_STORE;
            end else begin
                ev.kind = EV_FLUSH;
                ev.redirect = q[i].taken ? q[i].target : q[i].pc + ADDR_W'(INSTR_BYTES);
            end
            return ev;
        end
    end
    return ev;
endfunction

// anything still to come out of the retire stage
function automatic bit has_output_left(input instr_t q[$], input int first);
    int i;
    for (i = first; i < q.size(); i++) begin
        if (!q[i].done || !silent(q[i])) begin
            return 1'b1;
        end
    end
    return 1'b0;
endfunction

`endif

// File: tests/tb_rob.sv
`timescale 1ns/1ps

module tb_rob;

    import rob_pkg::*;

    localparam int DEPTH   = DEF_DEPTH;
    localparam int DATA_W  = DEF_DATA_W;
    localparam int ADDR_W  = DEF_ADDR_W;
    localparam int REG_W   = DEF_REG_W;
    localparam int TAG_W   = $clog2(DEPTH);
    localparam int TIMEOUT = 1000;

    logic              clk = 1'b0;
    logic              arst_n;
    logic              alloc_en;
    rob_kind_e         alloc_kind;
    logic [REG_W-1:0]  alloc_rd;
    logic [ADDR_W-1:0] alloc_pc;
    logic              alloc_pred_taken;
    logic [TAG_W-1:0]  alloc_tag;
    logic              full;
    logic              wb_en;
    logic [TAG_W-1:0]  wb_tag;
    logic [DATA_W-1:0] wb_data;
    logic              wb_taken;
    logic [ADDR_W-1:0] wb_target;
    logic              st_en;
    logic [TAG_W-1:0]  st_tag;
    logic              commit_en;
    logic [REG_W-1:0]  commit_rd;
    logic [DATA_W-1:0] commit_data;
    logic [TAG_W-1:0]  commit_tag;
    logic              store_release_en;
    logic [TAG_W-1:0]  store_release_tag;
    logic              flush;
    logic [ADDR_W-1:0] redirect_pc;

    `include "tb_rob_model.svh"

    // every instruction ever allocated in program order
    instr_t           rob_q[$];
    // tags still waiting for a writeback
    logic [TAG_W-1:0] pending[$];
    logic [TAG_W-1:0] next_tag;
    // oldest instruction not yet accounted for at retire
    int               retired  = 0;
    int               n_commit = 0;
    int               n_store  = 0;
    int               n_flush  = 0;

    rob_top #(
        .DEPTH  (DEPTH),
        .DATA_W (DATA_W),
        .ADDR_W (ADDR_W),
        .REG_W  (REG_W)
    ) dut0 (.*);

    always #50 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic fail_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        abort_run($sformatf("FAIL t=%0t %s got=0x%0h expected=0x%0h", $time, name, got, exp));
    endtask

    task automatic send_alloc();
        instr_t ins;
        int pick;
        pick = $urandom_range(3, 0);
        ins = '0;
        ins.kind = (pick == 2) ? KIND_BRANCH : (pick == 3) ? KIND_STORE : KIND_ALU;
        ins.tag  = next_tag;
        ins.rd   = REG_W'($urandom);
        ins.pc   = ADDR_W'($urandom) & ~ADDR_W'(3);
        ins.pred = 1'($urandom_range(1, 0));
        assert (alloc_tag == next_tag)
            else fail_value("alloc_tag", 64'(alloc_tag), 64'(next_tag));
        alloc_en         = 1'b1;
        alloc_kind       = ins.kind;
        alloc_rd         = ins.rd;
        alloc_pc         = ins.pc;
        alloc_pred_taken = ins.pred;
        rob_q.push_back(ins);
        pending.push_back(ins.tag);
        next_tag = (next_tag == TAG_W'(DEPTH - 1)) ? '0 : next_tag + TAG_W'(1);
    endtask

    task automatic send_writeback(input logic [TAG_W-1:0] tag);
        instr_t ins;
        int i;
        for (i = retired; i < rob_q.size(); i++) begin
            ins = rob_q[i];
            if (ins.tag == tag && !ins.done) begin
                ins.done = 1'b1;
                if (ins.kind == KIND_STORE) begin
                    st_en  = 1'b1;
                    st_tag = tag;
                end else begin
                    // direction disagrees with the guess one time in four
                    ins.data   = DATA_W'($urandom);
                    ins.taken  = ins.pred ^ ($urandom_range(3, 0) == 0);
                    ins.target = ADDR_W'($urandom) & ~ADDR_W'(3);
                    wb_en      = 1'b1;
                    wb_tag     = tag;
                    wb_data    = ins.data;
                    wb_taken   = ins.taken;
                    wb_target  = ins.target;
                end
                rob_q[i] = ins;
                return;
            end
        end
        abort_run("written-back tag has no waiting instruction in the model");
    endtask

    // odds are out of four per cycle
    task automatic drive_cycle(input int alloc_odds, input int wb_odds);
        int idx;
        @(posedge clk);
        #1;
        alloc_en = 1'b0;
        wb_en    = 1'b0;
        st_en    = 1'b0;
        if (flush) begin
            // whole window dropped and tags restart at 0
            pending.delete();
            next_tag = '0;
        end else begin
            if (pending.size() > 0 && $urandom_range(3, 0) < wb_odds) begin
                idx = $urandom_range(pending.size() - 1, 0);
                send_writeback(pending[idx]);
                pending.delete(idx);
            end
            if (!full && $urandom_range(3, 0) < alloc_odds) begin
                send_alloc();
            end
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (pending.size() > 0 || has_output_left(rob_q, retired)) begin
            assert (waited < TIMEOUT)
                else abort_run("timed out waiting for the reorder buffer to drain");
            drive_cycle(0, 4);
            waited++;
        end
    endtask

    // with no writebacks nothing retires and the buffer fills up
    task automatic fill_until_full();
        int n;
        for (n = 0; n < DEPTH; n++) begin
            drive_cycle(4, 0);
            assert (alloc_en) else abort_run("full rose before DEPTH allocations");
        end
        drive_cycle(0, 0);
        assert (full) else abort_run("full stayed low after DEPTH allocations");
    endtask

    task automatic resume_until_free();
        int waited;
        waited = 0;
        while (full) begin
            assert (waited < TIMEOUT) else abort_run("full never fell after writebacks resumed");
            drive_cycle(0, 4);
            waited++;
        end
    endtask

    task automatic check_event();
        expect_t ev;
        ev = expected_event(rob_q, retired);
        assert (ev.kind != EV_NONE)
            else abort_run("retire output seen while no instruction was ready to retire");
        if (ev.kind == EV_COMMIT) begin
            assert (commit_en) else abort_run("expected a register commit, saw another event");
            assert (commit_rd == ev.rd)
                else fail_value("commit_rd", 64'(commit_rd), 64'(ev.rd));
            assert (commit_data == ev.data)
                else fail_value("commit_data", 64'(commit_data), 64'(ev.data));
            assert (commit_tag == ev.tag)
                else fail_value("commit_tag", 64'(commit_tag), 64'(ev.tag));
            n_commit++;
            retired = ev.next_idx;
        end else if (ev.kind == EV_STORE) begin
            assert (store_release_en) else abort_run("expected a store release, saw another event");
            assert (store_release_tag == ev.tag)
                else fail_value("store_release_tag", 64'(store_release_tag), 64'(ev.tag));
            n_store++;
            retired = ev.next_idx;
        end else begin
            assert (flush) else abort_run("expected a flush, saw another event");
            assert (redirect_pc == ev.redirect)
                else fail_value("redirect_pc", 64'(redirect_pc), 64'(ev.redirect));
            n_flush++;
            // younger instructions never retire
            retired = rob_q.size();
        end
    endtask

    always @(negedge clk) begin
        if (arst_n && (commit_en || store_release_en || flush)) begin
            check_event();
        end
    end

    initial begin
        void'($urandom(27));
        arst_n           = 1'b0;
        alloc_en         = 1'b0;
        alloc_kind       = KIND_ALU;
        alloc_rd         = '0;
        alloc_pc         = '0;
        alloc_pred_taken = 1'b0;
        wb_en            = 1'b0;
        wb_tag           = '0;
        wb_data          = '0;
        wb_taken         = 1'b0;
        wb_target        = '0;
        st_en            = 1'b0;
        st_tag           = '0;
        next_tag         = '0;
        repeat (2) @(posedge clk);
        #1;
        arst_n = 1'b1;
        repeat (800) drive_cycle(3, 3);
        drain();
        fill_until_full();
        resume_until_free();
        repeat (400) drive_cycle(3, 3);
        drain();
        if (n_commit == 0 || n_store == 0 || n_flush == 0) begin
            abort_run("run ended without every kind of retire event");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: list.f
+incdir+tests
rtl/rob_pkg.sv
rtl/rob_alloc.sv
rtl/rob_entries.sv
rtl/rob_retire.sv
rtl/rob_top.sv
tests/tb_rob.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_rob
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := rtl/rob_pkg.sv \
           rtl/rob_alloc.sv \
           rtl/rob_entries.sv \
           rtl/rob_retire.sv \
           rtl/rob_top.sv \
           tests/tb_rob.sv \
           tests/tb_rob_model.svh

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
